/* rtl/biquad_pkg.sv */
package biquad_pkg;

   // sample formats, in and out
   localparam int NBITS = 16;
   localparam int NFRAC = 2;
   localparam int NSAMP = 8;
   localparam int OUTBITS = 16;

   // coefficients are Q4.14
   localparam int COEFF_BITS = 18;
   localparam int COEFF_FRAC = 14;
   localparam int NCOEFF = 2;

   // bus
   localparam int ADR_BITS = 7;
   localparam int WB_DAT_BITS = 32;
   localparam int WB_SEL_BITS = WB_DAT_BITS / 8;

   // datapath widths
   localparam int PROD_BITS = 34;
   localparam int SUM_BITS = 35;
   localparam int FIR_LATENCY = 3;

   // derived values
   localparam int IDX_BITS = $clog2(NCOEFF);
   localparam int SUM_FRAC = NFRAC + COEFF_FRAC;
   localparam int RND_SHIFT = SUM_FRAC - NFRAC;
   localparam int RND_HALF = 2 ** (RND_SHIFT - 1);
   localparam int SAT_MAX = 2 ** (OUTBITS - 1) - 1;
   localparam int SAT_MIN = -(2 ** (OUTBITS - 1));

   // control register bits
   localparam int CTRL_UPDATE_BIT = 0;
   localparam int CTRL_IDXCLR_BIT = 1;

   // register map, word aligned
   typedef enum logic [ADR_BITS-1:0] {
      REG_CTRL  = 7'h00,
      REG_COEFF = 7'h04
   } reg_addr_e;

   typedef enum logic {
      CS_IDLE,
      CS_ACK
   } ctrl_state_e;

   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [ADR_BITS-1:0]    adr;
      logic [WB_SEL_BITS-1:0] sel;
      logic [WB_DAT_BITS-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic                   ack;
      logic [WB_DAT_BITS-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic                  wr;
      logic                  update;
      logic                  index_clr;
      logic [COEFF_BITS-1:0] data;
   } coeff_cmd_t;

   typedef struct packed {
      logic signed [COEFF_BITS-1:0] b0;
      logic signed [COEFF_BITS-1:0] b1;
   } coeff_set_t;

   // lane 0 in the low bits
   typedef struct packed {
      logic [NSAMP-1:0][SUM_BITS-1:0] lane;
   } lane_sum_t;

endpackage

/* rtl/coeff_wb_ctrl.sv */
module coeff_wb_ctrl (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  biquad_pkg::wb_req_t    wb_req_i,
   input  logic                   global_update_i,
   output biquad_pkg::wb_rsp_t    wb_rsp_o,
   output biquad_pkg::coeff_cmd_t coeff_cmd_o
);
   import biquad_pkg::*;

   ctrl_state_e           state_q;
   ctrl_state_e           state_d;
   logic                  accept;
   logic                  ack;
   logic [ADR_BITS-1:0]   adr_word;
   logic                  hit_ctrl;
   logic                  hit_coeff;
   logic                  byte0_wr;

   // decode of the accepted request, used on the ack cycle
   logic                  coeff_wr_q;
   logic                  ctrl_upd_q;
   logic                  ctrl_clr_q;
   logic [COEFF_BITS-1:0] coeff_dat_q;

   // global update, one cycle late
   logic                  glob_upd_q;

   // low two address bits are don't care
   assign adr_word = {wb_req_i.adr[ADR_BITS-1:2], 2'b00};
   assign hit_ctrl = (adr_word == REG_CTRL);
   assign hit_coeff = (adr_word == REG_COEFF);

   assign ack = (state_q == CS_ACK);
   assign accept = wb_req_i.cyc && wb_req_i.stb && (state_q == CS_IDLE);
   assign byte0_wr = wb_req_i.we && wb_req_i.sel[0];

   always_comb begin
      state_d = state_q;
      case (state_q)
         CS_IDLE: begin
            if (accept) begin
               state_d = CS_ACK;
            end
         end
         CS_ACK: begin
            // single cycle ack, then ready for the next request
            state_d = CS_IDLE;
         end
         default: begin
            state_d = CS_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= CS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         coeff_wr_q <= 1'b0;
         ctrl_upd_q <= 1'b0;
         ctrl_clr_q <= 1'b0;
      end else if (accept) begin
         coeff_wr_q <= wb_req_i.we && hit_coeff;
         ctrl_upd_q <= byte0_wr && hit_ctrl && wb_req_i.dat[CTRL_UPDATE_BIT];
         ctrl_clr_q <= byte0_wr && hit_ctrl && wb_req_i.dat[CTRL_IDXCLR_BIT];
      end
   end

   // coefficient payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         coeff_dat_q <= wb_req_i.dat[COEFF_BITS-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         glob_upd_q <= 1'b0;
      end else begin
         glob_upd_q <= global_update_i;
      end
   end

   // no readback, reads just get acked
   always_comb begin
      wb_rsp_o.ack = ack;
      wb_rsp_o.dat = '0;
   end

   always_comb begin
      coeff_cmd_o.wr = ack && coeff_wr_q;
      coeff_cmd_o.index_clr = ack && ctrl_clr_q;
      coeff_cmd_o.update = (ack && ctrl_upd_q) || glob_upd_q;
      coeff_cmd_o.data = coeff_dat_q;
   end

endmodule

/* rtl/coeff_bank.sv */
module coeff_bank (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  biquad_pkg::coeff_cmd_t coeff_cmd_i,
   output biquad_pkg::coeff_set_t coeff_o
);
   import biquad_pkg::*;

   logic [IDX_BITS-1:0]          idx_q;
   logic [IDX_BITS-1:0]          wr_idx;
   logic [IDX_BITS-1:0]          next_idx;
   logic signed [COEFF_BITS-1:0] shadow_q [NCOEFF];
   coeff_set_t                   active_q;

   // clear wins over the stored index for the same write
   always_comb begin
      wr_idx = coeff_cmd_i.index_clr ? '0 : idx_q;
      if (wr_idx == IDX_BITS'(NCOEFF - 1)) begin
         next_idx = '0;
      end else begin
         next_idx = wr_idx + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         idx_q <= '0;
         for (int i = 0; i < NCOEFF; i++) begin
            shadow_q[i] <= '0;
         end
      end else if (coeff_cmd_i.wr) begin
         shadow_q[wr_idx] <= coeff_cmd_i.data;
         idx_q <= next_idx;
      end else if (coeff_cmd_i.index_clr) begin
         idx_q <= '0;
      end
   end

   // both coefficients move together, never a mixed pair
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         active_q <= '0;
      end else if (coeff_cmd_i.update) begin
         active_q.b0 <= shadow_q[0];
         active_q.b1 <= shadow_q[1];
      end
   end

   assign coeff_o = active_q;

endmodule

/* rtl/zero_fir8.sv */
module zero_fir8 (
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  logic [biquad_pkg::NSAMP*biquad_pkg::NBITS-1:0] dat_i,
   input  biquad_pkg::coeff_set_t                        coeff_i,
   output biquad_pkg::lane_sum_t                         sum_o
);
   import biquad_pkg::*;

   // current and previous sample per lane
   logic signed [NBITS-1:0]     x [NSAMP];
   logic signed [NBITS-1:0]     x_prev [NSAMP];

   // last lane of the previous word
   logic signed [NBITS-1:0]     carry_q;

   logic signed [PROD_BITS-1:0] prod_b0_q [NSAMP];
   logic signed [PROD_BITS-1:0] prod_b1_q [NSAMP];
   lane_sum_t                   sum_q;

   always_comb begin
      for (int k = 0; k < NSAMP; k++) begin
         x[k] = dat_i[k*NBITS +: NBITS];
      end
      // lane 0 is the oldest, its x[k-1] crosses the word boundary
      x_prev[0] = carry_q;
      for (int k = 1; k < NSAMP; k++) begin
         x_prev[k] = x[k-1];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         carry_q <= '0;
      end else begin
         carry_q <= x[NSAMP-1];
      end
   end

   // stage 1, products
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int k = 0; k < NSAMP; k++) begin
            prod_b0_q[k] <= '0;
            prod_b1_q[k] <= '0;
         end
      end else begin
         for (int k = 0; k < NSAMP; k++) begin
            prod_b0_q[k] <= $signed(coeff_i.b0) * x[k];
            prod_b1_q[k] <= $signed(coeff_i.b1) * x_prev[k];
         end
      end
   end

   // stage 2, lane sums with SUM_FRAC fractional bits
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         sum_q <= '0;
      end else begin
         for (int k = 0; k < NSAMP; k++) begin
            sum_q.lane[k] <= SUM_BITS'(prod_b0_q[k]) + SUM_BITS'(prod_b1_q[k]);
         end
      end
   end

   assign sum_o = sum_q;

endmodule

/* rtl/round_sat8.sv */
module round_sat8 (
   input  logic                                            clk_i,
   input  logic                                            rst_n_i,
   input  biquad_pkg::lane_sum_t                           sum_i,
   output logic [biquad_pkg::NSAMP*biquad_pkg::OUTBITS-1:0] dat_o
);
   import biquad_pkg::*;

   logic signed [SUM_BITS-1:0]    rounded [NSAMP];
   logic signed [SUM_BITS-1:0]    shifted [NSAMP];
   logic [NSAMP-1:0][OUTBITS-1:0] sat;

   always_comb begin
      for (int k = 0; k < NSAMP; k++) begin
         // add half an output LSB, halves round upward
         rounded[k] = $signed(sum_i.lane[k]) + SUM_BITS'(RND_HALF);
         shifted[k] = rounded[k] >>> RND_SHIFT;

         // clamp to the signed output range
         if (shifted[k] > SUM_BITS'(SAT_MAX)) begin
            sat[k] = OUTBITS'(SAT_MAX);
         end else if (shifted[k] < SUM_BITS'(SAT_MIN)) begin
            sat[k] = OUTBITS'(SAT_MIN);
         end else begin
            sat[k] = shifted[k][OUTBITS-1:0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dat_o <= '0;
      end else begin
         dat_o <= sat;
      end
   end

endmodule

/* rtl/zero_fir8_top.sv */
module zero_fir8_top (
   input  logic                                            clk_i,
   input  logic                                            rst_n_i,
   input  biquad_pkg::wb_req_t                             wb_req_i,
   input  logic                                            global_update_i,
   input  logic [biquad_pkg::NSAMP*biquad_pkg::NBITS-1:0]   dat_i,
   output biquad_pkg::wb_rsp_t                             wb_rsp_o,
   output logic [biquad_pkg::NSAMP*biquad_pkg::OUTBITS-1:0] dat_o
);
   import biquad_pkg::*;

   coeff_cmd_t coeff_cmd;
   coeff_set_t coeff_set;
   lane_sum_t  lane_sum;

   // register target
   coeff_wb_ctrl u_ctrl (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .wb_req_i        (wb_req_i),
      .global_update_i (global_update_i),
      .wb_rsp_o        (wb_rsp_o),
      .coeff_cmd_o     (coeff_cmd)
   );

   coeff_bank u_bank (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .coeff_cmd_i (coeff_cmd),
      .coeff_o     (coeff_set)
   );

   // two register stages
   zero_fir8 u_fir (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .dat_i   (dat_i),
      .coeff_i (coeff_set),
      .sum_o   (lane_sum)
   );

   // one register stage
   round_sat8 u_out (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .sum_i   (lane_sum),
      .dat_o   (dat_o)
   );

endmodule

/* tb/zero_fir8_tb.sv */
module zero_fir8_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import biquad_pkg::*;

   localparam int WORD_BITS = NSAMP * NBITS;
   localparam int RST_CYCLES = 10;
   localparam int N_ZERO_WORDS = 200;
   localparam int N_RAND_WORDS = 1000;
   localparam int N_FULL_WORDS = 400;
   localparam int N_MID_WORDS = 500;
   localparam int N_WRAP_WORDS = 400;
   localparam int OVERHEAD_CYCLES = 1000;
   localparam int PLANNED_CYCLES = RST_CYCLES + N_ZERO_WORDS + N_RAND_WORDS + N_FULL_WORDS
                                   + 3 * N_MID_WORDS + N_WRAP_WORDS + OVERHEAD_CYCLES;
   localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;
   localparam int ACK_WAIT_MAX = 8;

   // stimulus modes of the sample driver
   localparam int MODE_ZERO = 0;
   localparam int MODE_RANDOM = 1;
   localparam int MODE_FULL = 2;
   localparam int MODE_FIXED = 3;

   // control register values
   localparam logic [31:0] CTRL_UPDATE = 32'h1;
   localparam logic [31:0] CTRL_CLEAR = 32'h2;

   // odd inputs times 0.5, every lane lands on a half
   localparam logic [WORD_BITS-1:0] HALF_WORD = {16'hfff9, 16'h0007, 16'hfffb, 16'h0005,
                                                 16'hfffd, 16'h0003, 16'hffff, 16'h0001};
   localparam logic [WORD_BITS-1:0] HALF_EXP = {16'hfffd, 16'h0004, 16'hfffe, 16'h0003,
                                                16'hffff, 16'h0002, 16'h0000, 16'h0001};

   logic                 clk_i;
   logic                 rst_n_i;
   wb_req_t              wb_req;
   wb_rsp_t              wb_rsp;
   logic                 global_update_i;
   logic [WORD_BITS-1:0] dat_i;
   logic [WORD_BITS-1:0] dat_o;

   int                   seed = 32'h1a37;
   int                   data_mode;
   int                   drive_mode;
   logic [WORD_BITS-1:0] fixed_word;
   logic [WORD_BITS-1:0] drive_word;
   int                   cycle_cnt;
   int                   bus_cnt;
   int                   ack_cnt;
   int                   checked_cnt;

   // reference model state
   logic                        model_on;
   logic signed [NBITS-1:0]     mdl_carry;
   logic signed [COEFF_BITS-1:0] mdl_b0;
   logic signed [COEFF_BITS-1:0] mdl_b1;
   logic signed [COEFF_BITS-1:0] mdl_shadow [NCOEFF];
   int                          mdl_idx;
   logic [WORD_BITS-1:0]        exp_q [$];

   zero_fir8_top u_zero_fir8_top (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .wb_req_i        (wb_req),
      .global_update_i (global_update_i),
      .dat_i           (dat_i),
      .wb_rsp_o        (wb_rsp),
      .dat_o           (dat_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [WORD_BITS-1:0] exp,
                              input logic [WORD_BITS-1:0] act);
      if (exp !== act) begin
         report_failure($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act));
      end
   endtask

   // Q4.14 times Q13.2, round half up, clamp to 16 bits
   function automatic logic [OUTBITS-1:0] round_saturate(input longint acc);
      longint q;
      q = (acc + (longint'(1) <<< (COEFF_FRAC - 1))) >>> COEFF_FRAC;
      if (q > 32767) begin
         return 16'h7fff;
      end else if (q < -32768) begin
         return 16'h8000;
      end
      return q[OUTBITS-1:0];
   endfunction

   function automatic logic [WORD_BITS-1:0] expected_word(
         input logic [WORD_BITS-1:0] word, input logic signed [NBITS-1:0] prev,
         input logic signed [COEFF_BITS-1:0] b0, input logic signed [COEFF_BITS-1:0] b1);
      logic [WORD_BITS-1:0]    result;
      logic signed [NBITS-1:0] x;
      logic signed [NBITS-1:0] xp;
      longint                  acc;
      result = '0;
      for (int k = 0; k < NSAMP; k++) begin
         x = word[k*NBITS +: NBITS];
         // lane 0 reaches back into the previous word
         xp = (k == 0) ? prev : word[(k-1)*NBITS +: NBITS];
         acc = longint'(b0) * longint'(x) + longint'(b1) * longint'(xp);
         result[k*OUTBITS +: OUTBITS] = round_saturate(acc);
      end
      return result;
   endfunction

   function automatic logic [WORD_BITS-1:0] random_word();
      logic [WORD_BITS-1:0] w;
      for (int i = 0; i < WORD_BITS / 32; i++) begin
         w[i*32 +: 32] = $random(seed);
      end
      return w;
   endfunction

   // mostly the two rails, some random lanes mixed in
   function automatic logic [WORD_BITS-1:0] full_scale_word();
      logic [WORD_BITS-1:0] w;
      int                   r;
      for (int k = 0; k < NSAMP; k++) begin
         r = $random(seed);
         case (r[1:0])
            2'd0: w[k*NBITS +: NBITS] = 16'h7fff;
            2'd1: w[k*NBITS +: NBITS] = 16'h8000;
            default: w[k*NBITS +: NBITS] = r[31:16];
         endcase
      end
      return w;
   endfunction

   // sample driver, mode is taken at the edge and applied 1 ns later
   always @(posedge clk_i) begin
      drive_mode = data_mode;
      drive_word = fixed_word;
      #1;
      case (drive_mode)
         MODE_RANDOM: dat_i = random_word();
         MODE_FULL: dat_i = full_scale_word();
         MODE_FIXED: dat_i = drive_word;
         default: dat_i = '0;
      endcase
   end

   // output checker, one word pushed per clock, compared FIR_LATENCY words later
   always @(negedge clk_i) begin
      if (model_on) begin
         if (exp_q.size() == FIR_LATENCY) begin
            check_value("dat_o", exp_q.pop_front(), dat_o);
            checked_cnt++;
         end
         exp_q.push_back(expected_word(dat_i, mdl_carry, mdl_b0, mdl_b1));
         mdl_carry = dat_i[WORD_BITS-1 -: NBITS];
         if (wb_rsp.ack) begin
            ack_cnt++;
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         report_failure($sformatf("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES));
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // zeros long enough to flush the pipeline before the pair changes
   task automatic drain_stream();
      data_mode = MODE_ZERO;
      wait_cycles(FIR_LATENCY + 2);
   endtask

   task automatic bus_cycle(input logic we, input logic [ADR_BITS-1:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdata);
      int waited;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we = we;
      wb_req.adr = adr;
      wb_req.sel = sel;
      wb_req.dat = dat;
      waited = 0;
      do begin
         @(posedge clk_i);
         #1;
         waited++;
      end while (!wb_rsp.ack && waited < ACK_WAIT_MAX);
      if (!wb_rsp.ack) begin
         report_failure($sformatf("bus access to 0x%0h never got an ack", adr));
      end
      check_value("ack_latency", 1, waited);
      rdata = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we = 1'b0;
      bus_cnt++;
   endtask

   task automatic wb_write(input logic [ADR_BITS-1:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
      logic [31:0]         rdata;
      logic [ADR_BITS-1:0] adr_word;
      bus_cycle(1'b1, adr, dat, sel, rdata);
      adr_word = {adr[ADR_BITS-1:2], 2'b00};
      // bank registers take the write at the edge after ack
      @(posedge clk_i);
      if (adr_word == REG_COEFF) begin
         mdl_shadow[mdl_idx] = dat[COEFF_BITS-1:0];
         mdl_idx = (mdl_idx + 1) % NCOEFF;
      end else if (adr_word == REG_CTRL && sel[0]) begin
         if (dat[1]) begin
            mdl_idx = 0;
         end
         if (dat[0]) begin
            mdl_b0 = mdl_shadow[0];
            mdl_b1 = mdl_shadow[1];
         end
      end
      #1;
      check_value("ack", 0, wb_rsp.ack);
   endtask

   task automatic wb_read(input logic [ADR_BITS-1:0] adr);
      logic [31:0] rdata;
      bus_cycle(1'b0, adr, 32'h0, 4'hf, rdata);
      check_value("wb_rsp.dat", 0, rdata);
      wait_cycles(1);
      check_value("ack", 0, wb_rsp.ack);
   endtask

   task automatic bus_gap(input bit random_gaps);
      if (random_gaps) begin
         wait_cycles($random(seed) & 7);
      end
   endtask

   task automatic load_pair(input logic [COEFF_BITS-1:0] b0, input logic [COEFF_BITS-1:0] b1,
                            input bit random_gaps);
      wb_write(REG_CTRL, CTRL_CLEAR, 4'h1);
      bus_gap(random_gaps);
      wb_write(REG_COEFF, 32'(b0), 4'hf);
      bus_gap(random_gaps);
      wb_write(REG_COEFF, 32'(b1), 4'hf);
      bus_gap(random_gaps);
      wb_write(REG_CTRL, CTRL_UPDATE, 4'h1);
   endtask

   task automatic pulse_global_update();
      global_update_i = 1'b1;
      wait_cycles(1);
      global_update_i = 1'b0;
      // registered pin, then the active set loads one edge later
      @(posedge clk_i);
      mdl_b0 = mdl_shadow[0];
      mdl_b1 = mdl_shadow[1];
      #1;
   endtask

   initial begin
      logic [COEFF_BITS-1:0] c0;
      logic [COEFF_BITS-1:0] c1;
      logic [COEFF_BITS-1:0] c2;
      logic [WORD_BITS-1:0]  ref_word;
      rst_n_i = 1'b0;
      wb_req = '0;
      global_update_i = 1'b0;
      dat_i = '0;
      data_mode = MODE_ZERO;
      fixed_word = '0;
      model_on = 1'b0;
      mdl_carry = '0;
      mdl_b0 = '0;
      mdl_b1 = '0;
      mdl_shadow[0] = '0;
      mdl_shadow[1] = '0;
      mdl_idx = 0;
      repeat (RST_CYCLES) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      model_on = 1'b1;
      check_value("dat_o", '0, dat_o);
      check_value("ack", 0, wb_rsp.ack);

      // zero pair, reads of both registers during the stream
      data_mode = MODE_RANDOM;
      wait_cycles(N_ZERO_WORDS);
      wb_read(REG_CTRL);
      wb_read(7'h06);

      drain_stream();
      load_pair(18'($random(seed)), 18'($random(seed)), 1'b0);
      data_mode = MODE_RANDOM;
      wait_cycles(N_RAND_WORDS);

      // saturation at both rails
      drain_stream();
      load_pair(18'h1ffff, 18'h1ffff, 1'b0);
      fixed_word = {NSAMP{16'h7fff}};
      data_mode = MODE_FIXED;
      wait_cycles(FIR_LATENCY + 4);
      check_value("dat_o", {NSAMP{16'h7fff}}, dat_o);
      fixed_word = {NSAMP{16'h8000}};
      wait_cycles(FIR_LATENCY + 4);
      check_value("dat_o", {NSAMP{16'h8000}}, dat_o);
      data_mode = MODE_FULL;
      wait_cycles(N_FULL_WORDS);

      // b0 of 0.5 puts every odd input on a half
      drain_stream();
      load_pair(18'h02000, 18'h00000, 1'b0);
      fixed_word = HALF_WORD;
      data_mode = MODE_FIXED;
      wait_cycles(FIR_LATENCY + 4);
      check_value("dat_o", HALF_EXP, dat_o);

      // shadow writes mid stream, pin update later
      drain_stream();
      load_pair(18'($random(seed)), 18'($random(seed)), 1'b0);
      c0 = $random(seed);
      c1 = $random(seed);
      data_mode = MODE_RANDOM;
      wait_cycles(N_MID_WORDS);
      wb_write(REG_CTRL, CTRL_CLEAR, 4'h1);
      wb_write(REG_COEFF, 32'(c0), 4'hf);
      wb_write(REG_COEFF, 32'(c1), 4'hf);
      wait_cycles(N_MID_WORDS);
      drain_stream();
      pulse_global_update();
      data_mode = MODE_RANDOM;
      wait_cycles(N_MID_WORDS);

      // same pair loaded with and without gaps must give the same word
      drain_stream();
      c0 = $random(seed);
      c1 = $random(seed);
      fixed_word = random_word();
      ref_word = expected_word(fixed_word, fixed_word[WORD_BITS-1 -: NBITS], c0, c1);
      load_pair(c0, c1, 1'b0);
      data_mode = MODE_FIXED;
      wait_cycles(FIR_LATENCY + 4);
      check_value("dat_o", ref_word, dat_o);
      drain_stream();
      load_pair(~c0, ~c1, 1'b0);
      drain_stream();
      load_pair(c0, c1, 1'b1);
      data_mode = MODE_FIXED;
      wait_cycles(FIR_LATENCY + 4);
      check_value("dat_o", ref_word, dat_o);

      // third write wraps back onto b0
      drain_stream();
      c0 = $random(seed);
      c1 = $random(seed);
      c2 = $random(seed);
      wb_write(REG_CTRL, CTRL_CLEAR, 4'h1);
      wb_write(REG_COEFF, 32'(c0), 4'hf);
      wb_write(REG_COEFF, 32'(c1), 4'hf);
      wb_write(REG_COEFF, 32'(c2), 4'hf);
      wb_write(REG_CTRL, CTRL_UPDATE, 4'h1);
      data_mode = MODE_RANDOM;
      wait_cycles(N_WRAP_WORDS);

      drain_stream();
      check_value("ack_count", bus_cnt, ack_cnt);
      if (checked_cnt < N_RAND_WORDS) begin
         report_failure("output checker compared fewer words than the stream sent");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

/* list.f */
rtl/biquad_pkg.sv
rtl/coeff_wb_ctrl.sv
rtl/coeff_bank.sv
rtl/zero_fir8.sv
rtl/round_sat8.sv
rtl/zero_fir8_top.sv
tb/zero_fir8_tb.sv
